// File: cnn_ctrl.f
cnn_pkg.sv
engine_if.sv
layer_sequencer.sv
pool_engine.sv
fc_engine.sv
cnn_ctrl.sv
cnn_ctrl_props.sv
tb_cnn_ctrl.sv

// File: cnn_ctrl.sv
`timescale 1ns/1ps

module cnn_ctrl #(
	parameter cnn_pkg::wgt_addr_t FC_WEIGHT_BASE = 16'd940,
	parameter cnn_pkg::feat_addr_t FC_DST_BASE = 12'd1000
) (
	input logic clk,
	input logic reset,
	input logic start,
	output cnn_pkg::feat_addr_t feature_addr,
	input cnn_pkg::word_t feature_rdata,
	output cnn_pkg::word_t feature_wdata,
	output logic feature_we,
	output cnn_pkg::wgt_addr_t weight_addr,
	input cnn_pkg::word_t weight_rdata,
	output logic done
);

	engine_if pool_bus ();
	engine_if fc_bus ();

	layer_sequencer i_layer_sequencer (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.feature_rdata (feature_rdata),
		.feature_addr  (feature_addr),
		.feature_wdata (feature_wdata),
		.feature_we    (feature_we),
		.done          (done),
		.pool          (pool_bus.sequencer),
		.fc            (fc_bus.sequencer)
	);

	pool_engine i_pool_engine (
		.clk   (clk),
		.reset (reset),
		.bus   (pool_bus.engine)
	);

	fc_engine #(
		.FC_WEIGHT_BASE (FC_WEIGHT_BASE),
		.FC_DST_BASE    (FC_DST_BASE)
	) i_fc_engine (
		.clk          (clk),
		.reset        (reset),
		.bus          (fc_bus.engine),
		.weight_addr  (weight_addr),
		.weight_rdata (weight_rdata)
	);

endmodule

// File: cnn_ctrl_props.sv
`timescale 1ns/1ps

module cnn_ctrl_props (
	input logic clk,
	input logic reset,
	input logic start,
	input cnn_pkg::feat_addr_t feature_addr,
	input logic feature_we,
	input logic done
);
	import cnn_pkg::*;

	a_reset_quiet: assert property (@(posedge clk) $fell(reset) |=> !done && !feature_we)
		else $error("done or feature_we is high after reset");

	// first fetch after start reads the top of memory
	a_first_fetch: assert property (@(posedge clk) disable iff (reset)
		$rose(start) |=> feature_addr == PROG_TOP)
		else $error("ERR feature_addr = %h, expected %h", feature_addr, PROG_TOP);

	a_no_write_done: assert property (@(posedge clk) disable iff (reset)
		done |-> !feature_we)
		else $error("feature memory written while done is high");

	a_done_holds: assert property (@(posedge clk) disable iff (reset)
		done && !start |=> done)
		else $error("done dropped without a start");

	a_start_clears: assert property (@(posedge clk) disable iff (reset)
		done && start |=> !done)
		else $error("done still high after start");

endmodule

bind cnn_ctrl cnn_ctrl_props i_cnn_ctrl_props (.*);

// File: cnn_pkg.sv
package cnn_pkg;

	typedef logic signed [19:0] word_t;     // feature, weight or result
	typedef logic signed [39:0] acc_t;      // fc accumulator
	typedef logic [19:0] instr_t;
	typedef logic [11:0] feat_addr_t;
	typedef logic [15:0] wgt_addr_t;

	typedef enum logic [2:0] {
		POOL = 3'd2,
		FC   = 3'd3,
		END  = 3'd4
	} opcode_t;

	typedef enum logic [2:0] {
		idle,
		fetch,
		decode,
		run,
		finish
	} seq_state_t;

	localparam feat_addr_t PROG_TOP = 12'd4095;   // program grows downward from here
	localparam int FRAC_BITS = 12;
	localparam int POOL_WIN = 2;

	// instruction fields
	localparam int OP_MSB = 19;
	localparam int OP_LSB = 17;

	localparam int POOL_CH_MSB = 16;
	localparam int POOL_CH_LSB = 13;
	localparam int POOL_SIZE_MSB = 9;
	localparam int POOL_SIZE_LSB = 0;

	localparam int FC_MAPS_MSB = 16;
	localparam int FC_MAPS_LSB = 12;
	localparam int FC_MSIZE_MSB = 11;
	localparam int FC_MSIZE_LSB = 8;
	localparam int FC_CLS_MSB = 7;
	localparam int FC_CLS_LSB = 0;

endpackage

// File: engine_if.sv
`timescale 1ns/1ps

interface engine_if ();
	import cnn_pkg::*;

	logic go;               // one-cycle start pulse
	instr_t instr;
	logic finished;         // one-cycle end pulse
	feat_addr_t mem_addr;
	word_t mem_wdata;
	logic mem_we;
	word_t mem_rdata;

	modport engine (
		input go,
		input instr,
		input mem_rdata,
		output finished,
		output mem_addr,
		output mem_wdata,
		output mem_we
	);

	modport sequencer (
		output go,
		output instr,
		output mem_rdata,
		input finished,
		input mem_addr,
		input mem_wdata,
		input mem_we
	);

endinterface

// File: fc_engine.sv
`timescale 1ns/1ps

module fc_engine #(
	parameter cnn_pkg::wgt_addr_t FC_WEIGHT_BASE = 16'd940,
	parameter cnn_pkg::feat_addr_t FC_DST_BASE = 12'd1000
) (
	input logic clk,
	input logic reset,
	engine_if.engine bus,
	output cnn_pkg::wgt_addr_t weight_addr,
	input cnn_pkg::word_t weight_rdata
);
	import cnn_pkg::*;

	typedef enum logic [1:0] {
		fc_idle,
		fc_read,
		fc_last,
		fc_write
	} fc_state_t;

	fc_state_t state;
	feat_addr_t maps;
	feat_addr_t msize;
	logic [7:0] classes;
	feat_addr_t n_total;    // features per class
	feat_addr_t cnt;
	logic [7:0] cls;
	logic last_class;
	logic rd_valid;         // product of last cycle's reads is on the inputs
	acc_t product;
	acc_t acc;

	assign maps = feat_addr_t'(bus.instr[FC_MAPS_MSB:FC_MAPS_LSB]);
	assign msize = feat_addr_t'(bus.instr[FC_MSIZE_MSB:FC_MSIZE_LSB]);
	assign classes = bus.instr[FC_CLS_MSB:FC_CLS_LSB];
	assign last_class = (cls == classes - 8'd1);

	assign product = bus.mem_rdata * weight_rdata;

	assign bus.mem_addr = (state == fc_write) ? FC_DST_BASE + feat_addr_t'(cls) : cnt;
	assign bus.mem_wdata = acc[FRAC_BITS + $bits(word_t) - 1:FRAC_BITS];
	assign bus.mem_we = (state == fc_write);
	assign bus.finished = (state == fc_write) && last_class;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fc_idle;
			cnt <= '0;
			cls <= '0;
			rd_valid <= 1'b0;
			weight_addr <= FC_WEIGHT_BASE;
		end else begin
			rd_valid <= (state == fc_read);
			case (state)
				fc_idle: begin
					if (bus.go) begin
						state <= fc_read;
						cnt <= '0;
						cls <= '0;
						weight_addr <= FC_WEIGHT_BASE;
					end
				end
				fc_read: begin
					weight_addr <= weight_addr + 16'd1;   // runs on across classes
					if (cnt == n_total - 12'd1)
						state <= fc_last;
					else
						cnt <= cnt + 12'd1;
				end
				fc_last: state <= fc_write;
				fc_write: begin
					cnt <= '0;
					if (last_class) begin
						state <= fc_idle;
					end else begin
						cls <= cls + 8'd1;
						state <= fc_read;
					end
				end
				default: state <= fc_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bus.go)
			n_total <= maps * msize * msize;
		if (bus.go || state == fc_write)
			acc <= '0;
		else if (rd_valid)
			acc <= acc + product;
	end

endmodule

// File: layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer (
	input logic clk,
	input logic reset,
	input logic start,
	input cnn_pkg::word_t feature_rdata,
	output cnn_pkg::feat_addr_t feature_addr,
	output cnn_pkg::word_t feature_wdata,
	output logic feature_we,
	output logic done,
	engine_if.sequencer pool,
	engine_if.sequencer fc
);
	import cnn_pkg::*;

	seq_state_t state;
	seq_state_t next_state;
	feat_addr_t pc;
	instr_t instr;
	logic fetch_phase;     // second fetch cycle, read data valid
	opcode_t op;
	logic eng_finished;

	assign op = opcode_t'(instr[OP_MSB:OP_LSB]);

	assign pool.instr = instr;
	assign fc.instr = instr;
	assign pool.mem_rdata = feature_rdata;
	assign fc.mem_rdata = feature_rdata;

	assign pool.go = (state == decode) && (op == POOL);
	assign fc.go = (state == decode) && (op == FC);

	assign eng_finished = (op == FC) ? fc.finished : pool.finished;

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (start)
					next_state = fetch;
			end
			fetch: begin
				if (fetch_phase)
					next_state = decode;
			end
			decode: begin
				case (op)
					POOL, FC: next_state = run;
					END: next_state = finish;
					default: next_state = fetch;   // unsupported opcode, skip it
				endcase
			end
			run: begin
				if (eng_finished)
					next_state = fetch;
			end
			finish: next_state = idle;
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
			pc <= PROG_TOP;
			fetch_phase <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= next_state;
			fetch_phase <= (state == fetch) && !fetch_phase;
			if (state == idle && start) begin
				pc <= PROG_TOP;
				done <= 1'b0;
			end else if (state == fetch && fetch_phase) begin
				pc <= pc - 12'd1;
			end
			if (state == decode && op == END)
				done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == fetch && fetch_phase)
			instr <= feature_rdata;
	end

	// the running engine owns the memory port, otherwise the program counter
	always_comb begin
		feature_addr = pc;
		feature_wdata = '0;
		feature_we = 1'b0;
		if (state == run) begin
			if (op == FC) begin
				feature_addr = fc.mem_addr;
				feature_wdata = fc.mem_wdata;
				feature_we = fc.mem_we;
			end else begin
				feature_addr = pool.mem_addr;
				feature_wdata = pool.mem_wdata;
				feature_we = pool.mem_we;
			end
		end
	end

endmodule

// File: pool_engine.sv
`timescale 1ns/1ps

module pool_engine (
	input logic clk,
	input logic reset,
	engine_if.engine bus
);
	import cnn_pkg::*;

	localparam logic [2:0] WRITE_PHASE = 3'(POOL_WIN * POOL_WIN);
	localparam feat_addr_t STEP = feat_addr_t'(POOL_WIN);

	logic busy;
	logic [2:0] phase;      // 0..3 window reads, then write
	feat_addr_t in_size;
	feat_addr_t half_size;
	feat_addr_t ch_count;
	feat_addr_t x;
	feat_addr_t row_addr;   // start of the current input row pair
	feat_addr_t out_cnt;
	feat_addr_t out_total;
	feat_addr_t rd_base;
	word_t max_val;
	logic last_out;

	assign in_size = feat_addr_t'(bus.instr[POOL_SIZE_MSB:POOL_SIZE_LSB]);
	assign ch_count = feat_addr_t'(bus.instr[POOL_CH_MSB:POOL_CH_LSB]);
	assign half_size = in_size / STEP;

	assign rd_base = row_addr + x;
	assign last_out = (out_cnt == out_total - 12'd1);

	always_comb begin
		case (phase)
			3'd0: bus.mem_addr = rd_base;
			3'd1: bus.mem_addr = rd_base + 12'd1;
			3'd2: bus.mem_addr = rd_base + in_size;
			3'd3: bus.mem_addr = rd_base + in_size + 12'd1;
			default: bus.mem_addr = out_cnt;
		endcase
	end

	// last read arrives in the write cycle itself
	assign bus.mem_wdata = (bus.mem_rdata > max_val) ? bus.mem_rdata : max_val;
	assign bus.mem_we = busy && (phase == WRITE_PHASE);
	assign bus.finished = busy && (phase == WRITE_PHASE) && last_out;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			phase <= '0;
			x <= '0;
			row_addr <= '0;
			out_cnt <= '0;
		end else if (bus.go) begin
			busy <= 1'b1;
			phase <= '0;
			x <= '0;
			row_addr <= '0;
			out_cnt <= '0;
		end else if (busy) begin
			if (phase == WRITE_PHASE) begin
				phase <= '0;
				out_cnt <= out_cnt + 12'd1;
				busy <= !last_out;
				if (x == in_size - STEP) begin
					x <= '0;
					row_addr <= row_addr + STEP * in_size;   // planes are contiguous
				end else begin
					x <= x + STEP;
				end
			end else begin
				phase <= phase + 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (phase == 3'd1)
			max_val <= bus.mem_rdata;
		else if ((phase == 3'd2 || phase == 3'd3) && bus.mem_rdata > max_val)
			max_val <= bus.mem_rdata;
		if (bus.go)
			out_total <= ch_count * half_size * half_size;
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn_ctrl \
	-f cnn_ctrl.f --Mdir obj_dir -o tb_cnn_ctrl
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_cnn_ctrl > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation stopped with status $sim_status"
	exit 1
fi
echo "simulation passed"
exit 0

// File: tb_cnn_ctrl.sv
`timescale 1ns/1ps

module tb_cnn_ctrl;
	import cnn_pkg::*;

	localparam int SIZE = 24;
	localparam int CHANNELS = 6;
	localparam int HALF = SIZE / 2;
	localparam int OUTS = CHANNELS * HALF * HALF;
	localparam int MAPS = 2;
	localparam int MSIZE = 12;
	localparam int N = MAPS * MSIZE * MSIZE;   // features per class
	localparam int CLASSES = 3;
	localparam int WBASE = 940;
	localparam int DBASE = 1000;
	localparam int FETCH_FLOOR = 4000;   // engines never touch addresses above this

	localparam instr_t POOL_INSTR = {3'(POOL), 4'(CHANNELS), 3'd0, 10'(SIZE)};
	localparam instr_t FC_INSTR = {3'(FC), 5'(MAPS), 4'(MSIZE), 8'(CLASSES)};
	localparam instr_t END_INSTR = {3'(END), 17'd0};

	localparam int RUN_CYCLES = OUTS * 5 + CLASSES * (N + 2) + 3 * 2;
	localparam int CYCLE_LIMIT = 2 * 2 * RUN_CYCLES + 20;   // two runs plus reset

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic start = 1'b0;
	feat_addr_t feature_addr;
	word_t feature_rdata = '0;
	word_t feature_wdata;
	logic feature_we;
	wgt_addr_t weight_addr;
	word_t weight_rdata = '0;
	logic done;

	word_t feature_mem [0:4095];
	word_t weight_mem [0:2047];
	word_t image [0:4095];       // input features and program
	word_t pooled [0:OUTS-1];
	word_t fc_ref [0:CLASSES-1];
	int last_fetch = 4096;
	int cycles = 0;

	cnn_ctrl i_cnn_ctrl (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.feature_addr  (feature_addr),
		.feature_rdata (feature_rdata),
		.feature_wdata (feature_wdata),
		.feature_we    (feature_we),
		.weight_addr   (weight_addr),
		.weight_rdata  (weight_rdata),
		.done          (done)
	);

	always #20 clk = ~clk;

	// both memories answer one cycle after the address
	always @(posedge clk) begin
		if (feature_we)
			feature_mem[feature_addr] <= feature_wdata;
		feature_rdata <= feature_mem[feature_addr];
		weight_rdata <= weight_mem[weight_addr[10:0]];
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			abort_run("run timed out before done was seen");
	end

	// each new program address must be one below the last
	always @(negedge clk) begin
		if (!reset && !done && feature_addr >= FETCH_FLOOR && feature_addr != last_fetch) begin
			assert (int'(feature_addr) == last_fetch - 1)
				else abort_run($sformatf("ERR feature_addr = %h, expected %h",
					feature_addr, feat_addr_t'(last_fetch - 1)));
			last_fetch = feature_addr;
		end
	end

	task automatic load_image();
		for (int a = 0; a < 4096; a++)
			feature_mem[a] = image[a];
	endtask

	task automatic compute_reference();
		int c;
		int r;
		int x;
		int base;
		word_t m;
		acc_t sum;
		for (int k = 0; k < OUTS; k++) begin
			c = k / (HALF * HALF);
			r = (k % (HALF * HALF)) / HALF;
			x = k % HALF;
			base = c * SIZE * SIZE + 2 * r * SIZE + 2 * x;
			m = image[base];
			if (image[base + 1] > m)
				m = image[base + 1];
			if (image[base + SIZE] > m)
				m = image[base + SIZE];
			if (image[base + SIZE + 1] > m)
				m = image[base + SIZE + 1];
			pooled[k] = m;
		end
		for (int cls = 0; cls < CLASSES; cls++) begin
			sum = '0;
			for (int i = 0; i < N; i++)
				sum = sum + acc_t'(pooled[i]) * acc_t'(weight_mem[WBASE + cls * N + i]);
			fc_ref[cls] = sum[31:FRAC_BITS];
		end
	endtask

	task automatic check_results();
		for (int k = 0; k < OUTS; k++) begin
			assert (feature_mem[k] == pooled[k])
				else abort_run($sformatf("ERR feature_mem[%h] = %h, expected %h",
					feat_addr_t'(k), feature_mem[k], pooled[k]));
		end
		for (int c = 0; c < CLASSES; c++) begin
			assert (feature_mem[DBASE + c] == fc_ref[c])
				else abort_run($sformatf("ERR feature_mem[%h] = %h, expected %h",
					feat_addr_t'(DBASE + c), feature_mem[DBASE + c], fc_ref[c]));
		end
	endtask

	task automatic wait_for_done();
		@(negedge clk);
		while (!done)
			@(negedge clk);
	endtask

	initial begin
		int seed_draw;
		seed_draw = $urandom(32'h33cf);
		for (int a = 0; a < 4096; a++)
			image[a] = (a < CHANNELS * SIZE * SIZE) ? word_t'($urandom) : '0;
		image[4095] = POOL_INSTR;
		image[4094] = FC_INSTR;
		image[4093] = END_INSTR;
		for (int a = 0; a < 2048; a++)
			weight_mem[a] = word_t'($urandom);
		load_image();
		compute_reference();

		repeat (4) @(posedge clk);
		reset <= 1'b0;

		for (int run = 0; run < 2; run++) begin
			if (run > 0)
				load_image();   // fresh input so the second run repeats the first
			@(posedge clk);
			last_fetch = 4096;
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			wait_for_done();
			check_results();
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
